// ==== hw/mini_mcu_pkg.sv ====
// ----------------------------------------
// sizes, address map and bus/power types for the banked RAM
// RAM banks are interleaved on byte address bits 11:10
// ----------------------------------------
package mini_mcu_pkg;

  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 256;
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int SEL_W      = 4;
  localparam int BANK_IDX_W = 2;
  localparam int WORD_IDX_W = 8;

  // address map
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] RAM_SIZE = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] PWR_BASE = 32'h0000_1000;

  // power register window is 16 bytes
  localparam int PWR_OFS_W = 4;
  localparam logic [PWR_OFS_W-1:0] PWR_OFF_REQ_OFS = 4'h0;
  localparam logic [PWR_OFS_W-1:0] PWR_RET_OFS     = 4'h4;
  localparam logic [PWR_OFS_W-1:0] PWR_STATUS_OFS  = 4'h8;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // a single target answers with the same fields as the bus
  typedef wb_rsp_t target_rsp_t;

  typedef struct packed {
    logic off_req;
    logic retentive;
  } bank_pwr_ctrl_t;

  // switch-cell controls, all active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } bank_pwr_out_t;

  typedef enum logic [2:0] {
    ON,
    ISOLATE,
    SWITCH_OFF,
    OFF,
    RETAIN,
    SWITCH_ON,
    RELEASE
  } bank_pwr_state_e;

endpackage

// ==== hw/bus_decoder.sv ====
// ----------------------------------------
// one strobe per cycle: a bank, the power regs or a miss
// power window ignores offsets, the regs reject unknown ones
// ----------------------------------------
`timescale 1ns/1ps

module bus_decoder (
  input  mini_mcu_pkg::wb_req_t               wb_i,
  output logic [mini_mcu_pkg::NUM_BANKS-1:0]  bank_stb_o,
  output logic                                pwr_stb_o,
  output logic                                miss_stb_o
);

  logic                                active;
  logic                                in_ram;
  logic                                in_pwr;
  logic [mini_mcu_pkg::ADDR_W-1:0]     ram_ofs;
  logic [mini_mcu_pkg::BANK_IDX_W-1:0] bank_idx;

  assign active = wb_i.cyc & wb_i.stb;

  // unsigned offset test also covers a base of zero
  assign ram_ofs = wb_i.adr - mini_mcu_pkg::RAM_BASE;
  assign in_ram  = (ram_ofs < mini_mcu_pkg::RAM_SIZE);

  assign in_pwr = (wb_i.adr[mini_mcu_pkg::ADDR_W-1:mini_mcu_pkg::PWR_OFS_W] ==
                   mini_mcu_pkg::PWR_BASE[mini_mcu_pkg::ADDR_W-1:mini_mcu_pkg::PWR_OFS_W]);

  // word interleave sits above the word index
  assign bank_idx = ram_ofs[mini_mcu_pkg::WORD_IDX_W + mini_mcu_pkg::BANK_IDX_W + 1 :
                            mini_mcu_pkg::WORD_IDX_W + 2];

  always_comb begin
    bank_stb_o = '0;
    if (active && in_ram) begin
      bank_stb_o[bank_idx] = 1'b1;
    end
  end

  assign pwr_stb_o  = active & ~in_ram & in_pwr;
  assign miss_stb_o = active & ~in_ram & ~in_pwr;

endmodule

// ==== hw/memory_bank.sv ====
// ----------------------------------------
// one RAM bank plus its power sequencer
// only ON accepts accesses, every other state answers err
// switch acknowledge comes from outside, low while off
// ----------------------------------------
`timescale 1ns/1ps

module memory_bank (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         stb_i,
  input  mini_mcu_pkg::wb_req_t        req_i,
  input  mini_mcu_pkg::bank_pwr_ctrl_t pwr_ctrl_i,
  input  logic                         pwrgate_ack_n_i,
  output mini_mcu_pkg::target_rsp_t    rsp_o,
  output mini_mcu_pkg::bank_pwr_out_t  pwr_o,
  output logic                         bank_on_o,
  output logic                         bank_down_o
);

  logic [mini_mcu_pkg::DATA_W-1:0]     mem [mini_mcu_pkg::BANK_WORDS];
  logic [mini_mcu_pkg::DATA_W-1:0]     rdata_q;
  logic [mini_mcu_pkg::WORD_IDX_W-1:0] word_idx;
  logic                                ack_q;
  logic                                err_q;
  logic                                access;
  logic                                bank_ready;
  mini_mcu_pkg::bank_pwr_state_e       state_q;
  mini_mcu_pkg::bank_pwr_state_e       state_d;

  assign word_idx   = req_i.adr[mini_mcu_pkg::WORD_IDX_W+1:2];
  // held strobe during our own response is not a new request
  assign access     = stb_i & ~(ack_q | err_q);
  assign bank_ready = (state_q == mini_mcu_pkg::ON);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access & bank_ready;
      err_q <= access & ~bank_ready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && bank_ready) begin
      if (req_i.we) begin
        for (int b = 0; b < mini_mcu_pkg::SEL_W; b++) begin
          if (req_i.sel[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = err_q;
  assign rsp_o.dat = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mini_mcu_pkg::ON:         if (pwr_ctrl_i.off_req) state_d = mini_mcu_pkg::ISOLATE;
      mini_mcu_pkg::ISOLATE:    state_d = pwr_ctrl_i.retentive ? mini_mcu_pkg::RETAIN
                                                               : mini_mcu_pkg::SWITCH_OFF;
      mini_mcu_pkg::SWITCH_OFF: if (!pwrgate_ack_n_i) state_d = mini_mcu_pkg::OFF;
      mini_mcu_pkg::OFF,
      mini_mcu_pkg::RETAIN:     if (!pwr_ctrl_i.off_req) state_d = mini_mcu_pkg::SWITCH_ON;
      // from RETAIN the switch never opened, so the ack is already high
      mini_mcu_pkg::SWITCH_ON:  if (pwrgate_ack_n_i) state_d = mini_mcu_pkg::RELEASE;
      mini_mcu_pkg::RELEASE:    state_d = mini_mcu_pkg::ON;
      default:                  state_d = mini_mcu_pkg::ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mini_mcu_pkg::ON;
    end else begin
      state_q <= state_d;
    end
  end

  // moore decode of the switch-cell controls
  always_comb begin
    pwr_o = '1;
    case (state_q)
      mini_mcu_pkg::ISOLATE,
      mini_mcu_pkg::SWITCH_ON: begin
        pwr_o.clkgate_en_n = 1'b0;
        pwr_o.isogate_en_n = 1'b0;
      end
      mini_mcu_pkg::SWITCH_OFF,
      mini_mcu_pkg::OFF: begin
        pwr_o.clkgate_en_n = 1'b0;
        pwr_o.isogate_en_n = 1'b0;
        pwr_o.pwrgate_en_n = 1'b0;
      end
      mini_mcu_pkg::RETAIN: begin
        pwr_o.clkgate_en_n   = 1'b0;
        pwr_o.isogate_en_n   = 1'b0;
        pwr_o.retentive_en_n = 1'b0;
      end
      default: ;
    endcase
  end

  assign bank_on_o   = (state_q == mini_mcu_pkg::ON);
  assign bank_down_o = (state_q == mini_mcu_pkg::OFF) || (state_q == mini_mcu_pkg::RETAIN);

endmodule

// ==== hw/power_ctrl_regs.sv ====
// ----------------------------------------
// off request, retention and status registers
// writes take byte lane 0 only
// status is read-only
// ----------------------------------------
`timescale 1ns/1ps

module power_ctrl_regs (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       stb_i,
  input  mini_mcu_pkg::wb_req_t                      req_i,
  input  logic [mini_mcu_pkg::NUM_BANKS-1:0]         bank_on_i,
  input  logic [mini_mcu_pkg::NUM_BANKS-1:0]         bank_down_i,
  output mini_mcu_pkg::target_rsp_t                  rsp_o,
  output mini_mcu_pkg::bank_pwr_ctrl_t [mini_mcu_pkg::NUM_BANKS-1:0] pwr_ctrl_o
);

  logic [mini_mcu_pkg::NUM_BANKS-1:0] off_req_q;
  logic [mini_mcu_pkg::NUM_BANKS-1:0] ret_q;
  logic [mini_mcu_pkg::DATA_W-1:0]    rd_data;
  logic [mini_mcu_pkg::DATA_W-1:0]    rdata_q;
  logic [mini_mcu_pkg::PWR_OFS_W-1:0] ofs;
  logic                               ack_q;
  logic                               err_q;
  logic                               access;
  logic                               ofs_ok;

  assign ofs    = req_i.adr[mini_mcu_pkg::PWR_OFS_W-1:0];
  assign access = stb_i & ~(ack_q | err_q);

  always_comb begin
    rd_data = '0;
    ofs_ok  = 1'b1;
    case (ofs)
      mini_mcu_pkg::PWR_OFF_REQ_OFS: rd_data[mini_mcu_pkg::NUM_BANKS-1:0] = off_req_q;
      mini_mcu_pkg::PWR_RET_OFS:     rd_data[mini_mcu_pkg::NUM_BANKS-1:0] = ret_q;
      mini_mcu_pkg::PWR_STATUS_OFS: begin
        rd_data[2*mini_mcu_pkg::NUM_BANKS-1:0] = {bank_down_i, bank_on_i};
        ofs_ok = ~req_i.we;
      end
      default: ofs_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      off_req_q <= '0;
      ret_q     <= '0;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      ack_q <= access & ofs_ok;
      err_q <= access & ~ofs_ok;
      if (access && req_i.we && req_i.sel[0]) begin
        if (ofs == mini_mcu_pkg::PWR_OFF_REQ_OFS) begin
          off_req_q <= req_i.dat[mini_mcu_pkg::NUM_BANKS-1:0];
        end
        if (ofs == mini_mcu_pkg::PWR_RET_OFS) begin
          ret_q <= req_i.dat[mini_mcu_pkg::NUM_BANKS-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !req_i.we) begin
      rdata_q <= rd_data;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = err_q;
  assign rsp_o.dat = rdata_q;

  always_comb begin
    for (int i = 0; i < mini_mcu_pkg::NUM_BANKS; i++) begin
      pwr_ctrl_o[i].off_req   = off_req_q[i];
      pwr_ctrl_o[i].retentive = ret_q[i];
    end
  end

endmodule

// ==== hw/wb_resp_mux.sv ====
// ----------------------------------------
// merges target responses onto the bus
// at most one target answers in a cycle
// ----------------------------------------
`timescale 1ns/1ps

module wb_resp_mux (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic                                                     miss_stb_i,
  input  mini_mcu_pkg::target_rsp_t [mini_mcu_pkg::NUM_BANKS-1:0] bank_rsp_i,
  input  mini_mcu_pkg::target_rsp_t                                pwr_rsp_i,
  output mini_mcu_pkg::wb_rsp_t                                    wb_o
);

  logic miss_err_q;

  // decode miss answers like any other target, one cycle late
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miss_err_q <= 1'b0;
    end else begin
      miss_err_q <= miss_stb_i & ~miss_err_q;
    end
  end

  always_comb begin
    wb_o.ack = pwr_rsp_i.ack;
    wb_o.err = pwr_rsp_i.err | miss_err_q;
    wb_o.dat = pwr_rsp_i.ack ? pwr_rsp_i.dat : '0;
    for (int i = 0; i < mini_mcu_pkg::NUM_BANKS; i++) begin
      wb_o.ack = wb_o.ack | bank_rsp_i[i].ack;
      wb_o.err = wb_o.err | bank_rsp_i[i].err;
      // read data only from the target that acks
      if (bank_rsp_i[i].ack) begin
        wb_o.dat = bank_rsp_i[i].dat;
      end
    end
  end

endmodule

// ==== hw/mini_mcu_top.sv ====
// ----------------------------------------
// banked RAM with per-bank power sequencing
// switch cells and their acks live outside this top
// ----------------------------------------
`timescale 1ns/1ps

module mini_mcu_top (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  mini_mcu_pkg::wb_req_t                                      wb_i,
  output mini_mcu_pkg::wb_rsp_t                                      wb_o,
  output mini_mcu_pkg::bank_pwr_out_t [mini_mcu_pkg::NUM_BANKS-1:0]  bank_pwr_o,
  input  logic [mini_mcu_pkg::NUM_BANKS-1:0]                         pwrgate_ack_n_i
);

  logic [mini_mcu_pkg::NUM_BANKS-1:0]                        bank_stb;
  logic                                                      pwr_stb;
  logic                                                      miss_stb;
  mini_mcu_pkg::target_rsp_t [mini_mcu_pkg::NUM_BANKS-1:0]   bank_rsp;
  mini_mcu_pkg::target_rsp_t                                 pwr_rsp;
  mini_mcu_pkg::bank_pwr_ctrl_t [mini_mcu_pkg::NUM_BANKS-1:0] pwr_ctrl;
  logic [mini_mcu_pkg::NUM_BANKS-1:0]                        bank_on;
  logic [mini_mcu_pkg::NUM_BANKS-1:0]                        bank_down;

  bus_decoder u_decoder (
    .wb_i       (wb_i),
    .bank_stb_o (bank_stb),
    .pwr_stb_o  (pwr_stb),
    .miss_stb_o (miss_stb)
  );

  for (genvar i = 0; i < mini_mcu_pkg::NUM_BANKS; i++) begin : g_bank
    memory_bank u_bank (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .stb_i           (bank_stb[i]),
      .req_i           (wb_i),
      .pwr_ctrl_i      (pwr_ctrl[i]),
      .pwrgate_ack_n_i (pwrgate_ack_n_i[i]),
      .rsp_o           (bank_rsp[i]),
      .pwr_o           (bank_pwr_o[i]),
      .bank_on_o       (bank_on[i]),
      .bank_down_o     (bank_down[i])
    );
  end

  power_ctrl_regs u_pwr_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stb_i       (pwr_stb),
    .req_i       (wb_i),
    .bank_on_i   (bank_on),
    .bank_down_i (bank_down),
    .rsp_o       (pwr_rsp),
    .pwr_ctrl_o  (pwr_ctrl)
  );

  wb_resp_mux u_resp_mux (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .miss_stb_i (miss_stb),
    .bank_rsp_i (bank_rsp),
    .pwr_rsp_i  (pwr_rsp),
    .wb_o       (wb_o)
  );

endmodule

// ==== tests/mini_mcu_chk.sv ====
// ----------------------------------------
// bus response timing and switch-cell order
// assumes the master drops stb between requests
// ----------------------------------------
`timescale 1ns/1ps

module mini_mcu_chk (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  mini_mcu_pkg::wb_req_t                                     wb_req_i,
  input  mini_mcu_pkg::wb_rsp_t                                     wb_rsp_i,
  input  mini_mcu_pkg::bank_pwr_out_t [mini_mcu_pkg::NUM_BANKS-1:0] bank_pwr_i
);

  logic        req_q;
  logic        new_req;
  int unsigned fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= wb_req_i.cyc & wb_req_i.stb;
    end
  end

  // first cycle a strobe is seen
  assign new_req = wb_req_i.cyc & wb_req_i.stb & ~req_q;

  a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    new_req |=> (wb_rsp_i.ack ^ wb_rsp_i.err))
    else begin
      fail_count++;
      $error("request not answered by exactly one of ack and err");
    end

  a_no_ack_and_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else begin
      fail_count++;
      $error("ack and err high together");
    end

  a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_rsp_i.ack || wb_rsp_i.err) |=> !(wb_rsp_i.ack || wb_rsp_i.err))
    else begin
      fail_count++;
      $error("response held longer than one cycle");
    end

  for (genvar i = 0; i < mini_mcu_pkg::NUM_BANKS; i++) begin : g_pwr
    a_iso_before_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(bank_pwr_i[i].pwrgate_en_n) |-> !bank_pwr_i[i].isogate_en_n)
      else begin
        fail_count++;
        $error("bank %0d switched off without isolation", i);
      end

    a_iso_release_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(bank_pwr_i[i].isogate_en_n) |->
        (bank_pwr_i[i].pwrgate_en_n && bank_pwr_i[i].retentive_en_n))
      else begin
        fail_count++;
        $error("bank %0d isolation released before power and retention", i);
      end
  end

endmodule

// ==== tests/tb_mini_mcu.sv ====
// ----------------------------------------
// drives the banked RAM over Wishbone and models the switch cells
// switch ack trails pwrgate_en_n by about 3 cycles
// ----------------------------------------
`timescale 1ns/1ps

module tb_mini_mcu;

  localparam int NB        = mini_mcu_pkg::NUM_BANKS;
  localparam int WORDS     = mini_mcu_pkg::BANK_WORDS;
  localparam int MAX_WAIT  = 20;
  localparam int MAX_POLLS = 40;
  // worst case near 260 two-clock bus cycles including every status poll
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] OFF_REQ_ADR =
    mini_mcu_pkg::PWR_BASE + 32'(mini_mcu_pkg::PWR_OFF_REQ_OFS);
  localparam logic [31:0] RET_ADR =
    mini_mcu_pkg::PWR_BASE + 32'(mini_mcu_pkg::PWR_RET_OFS);
  localparam logic [31:0] STATUS_ADR =
    mini_mcu_pkg::PWR_BASE + 32'(mini_mcu_pkg::PWR_STATUS_OFS);

  logic                                 clk = 1'b0;
  logic                                 rst_n = 1'b0;
  mini_mcu_pkg::wb_req_t                wb_req;
  mini_mcu_pkg::wb_rsp_t                wb_rsp;
  mini_mcu_pkg::bank_pwr_out_t [NB-1:0] bank_pwr;
  logic [NB-1:0]                        pwrgate_en_n;
  logic [NB-1:0]                        pwrgate_ack_n;
  logic [2:0][NB-1:0]                   switch_pipe = '1;
  logic [31:0]                          lfsr_state = 32'h8c6f_52fe;
  logic [31:0]                          shadow [NB*WORDS];
  logic [31:0]                          written_q [$];
  int                                   checks = 0;
  int                                   errors = 0;
  int                                   cycles = 0;

  always #10 clk = ~clk;

  mini_mcu_top u_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .wb_i            (wb_req),
    .wb_o            (wb_rsp),
    .bank_pwr_o      (bank_pwr),
    .pwrgate_ack_n_i (pwrgate_ack_n)
  );

  bind mini_mcu_top mini_mcu_chk u_chk (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_req_i   (wb_i),
    .wb_rsp_i   (wb_o),
    .bank_pwr_i (bank_pwr_o)
  );

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      pwrgate_en_n[i] = bank_pwr[i].pwrgate_en_n;
    end
  end

  // switch cells settle a few cycles after their enable
  always @(negedge clk) begin
    switch_pipe <= {switch_pipe[1:0], pwrgate_en_n};
  end

  assign pwrgate_ack_n = switch_pipe[2];

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing, %s %0d, %s %0d, %s %0d",
               cycles, "checks:", checks, "errors:", errors,
               "assertion failures:", u_dut.u_chk.fail_count);
      $display("Testbench failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // one classic cycle that starts and ends on a falling edge
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output mini_mcu_pkg::wb_rsp_t rsp);
    int waited;
    waited = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    do begin
      @(negedge clk);
      waited++;
    end while (!(wb_rsp.ack || wb_rsp.err) && waited < MAX_WAIT);
    rsp = wb_rsp;
    check_true($sformatf("bus cycle to %08h got neither ack nor err", adr),
               rsp.ack || rsp.err);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic acked);
    mini_mcu_pkg::wb_rsp_t rsp;
    bus_cycle(1'b1, adr, dat, sel, rsp);
    acked = rsp.ack;
    check_true($sformatf("write to %08h was not acknowledged", adr), rsp.ack && !rsp.err);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
    logic acked;
    write_reg(adr, dat, sel, acked);
    if (acked) begin
      shadow[adr[11:2]] = merge_bytes(shadow[adr[11:2]], dat, sel);
    end
  endtask

  task automatic read_expect(input string name, input logic [31:0] adr,
                             input logic [31:0] exp);
    mini_mcu_pkg::wb_rsp_t rsp;
    bus_cycle(1'b0, adr, '0, '1, rsp);
    check_true({name, ": read was not acknowledged"}, rsp.ack && !rsp.err);
    check_value(name, exp, rsp.dat);
  endtask

  task automatic expect_err(input string name, input logic we, input logic [31:0] adr,
                            input logic [31:0] dat);
    mini_mcu_pkg::wb_rsp_t rsp;
    bus_cycle(we, adr, dat, '1, rsp);
    check_true({name, ": access was not refused with err alone"}, rsp.err && !rsp.ack);
  endtask

  task automatic wait_status(input string name, input logic [31:0] mask,
                             input logic [31:0] exp);
    mini_mcu_pkg::wb_rsp_t rsp;
    int polls;
    polls = 0;
    do begin
      bus_cycle(1'b0, STATUS_ADR, '0, '1, rsp);
      polls++;
    end while (((rsp.dat & mask) !== exp) && polls < MAX_POLLS);
    check_true({name, ": status never reached the expected state"},
               (rsp.dat & mask) === exp);
  endtask

  initial begin
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        acked;
    wb_req = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < NB; i++) begin
      check_value("reset switch controls", 32'h0000_000f, 32'(bank_pwr[i]));
    end
    read_expect("reset status", STATUS_ADR, 32'h0000_000f);
    read_expect("reset off request", OFF_REQ_ADR, '0);
    read_expect("reset retention", RET_ADR, '0);

    // full write first so every later partial write merges onto known bytes
    for (int b = 0; b < NB; b++) begin
      for (int n = 0; n < 4; n++) begin
        adr = (32'(b) << 10) | (rand_bits(8) << 2);
        write_word(adr, rand_bits(32), 4'hf);
        dat = rand_bits(32);
        sel = 4'(rand_bits(4));
        write_word(adr, dat, sel);
        written_q.push_back(adr);
      end
    end
    for (int k = 0; k < written_q.size(); k++) begin
      adr = written_q[k];
      read_expect("random readback", adr, shadow[adr[11:2]]);
    end

    expect_err("decode miss read", 1'b0, 32'h0000_2000, '0);
    expect_err("decode miss write", 1'b1, 32'h8000_0000, 32'h1234_5678);
    expect_err("unknown power offset", 1'b0, mini_mcu_pkg::PWR_BASE + 32'hc, '0);
    expect_err("status write", 1'b1, STATUS_ADR, 32'hffff_ffff);

    // bank 1 fully off
    write_reg(OFF_REQ_ADR, 32'h2, 4'hf, acked);
    wait_status("bank 1 power down", 32'h22, 32'h20);
    read_expect("bank 1 off status", STATUS_ADR, 32'h0000_002d);
    check_value("bank 1 off controls", 32'h0000_0001, 32'(bank_pwr[1]));
    expect_err("bank 1 read while off", 1'b0, 32'h0000_0400, '0);
    expect_err("bank 1 write while off", 1'b1, 32'h0000_0404, 32'hdead_beef);
    for (int k = 0; k < written_q.size(); k++) begin
      adr = written_q[k];
      if (adr[11:10] != 2'd1) begin
        read_expect("readback while bank 1 off", adr, shadow[adr[11:2]]);
      end
    end
    write_reg(OFF_REQ_ADR, 32'h0, 4'hf, acked);
    wait_status("bank 1 wake", 32'hff, 32'h0f);
    read_expect("status after bank 1 wake", STATUS_ADR, 32'h0000_000f);

    // bank 2 in retention
    // queue entries 8 to 11 belong to bank 2
    write_reg(RET_ADR, 32'h4, 4'hf, acked);
    write_reg(OFF_REQ_ADR, 32'h4, 4'hf, acked);
    wait_status("bank 2 retention", 32'h44, 32'h40);
    check_value("bank 2 retention controls", 32'h0000_0008, 32'(bank_pwr[2]));
    check_true("bank 2 switch opened during retention", pwrgate_ack_n[2]);
    expect_err("bank 2 write while retained", 1'b1, written_q[8], 32'h0bad_f00d);
    write_reg(OFF_REQ_ADR, 32'h0, 4'hf, acked);
    wait_status("bank 2 wake", 32'hff, 32'h0f);
    for (int k = 0; k < written_q.size(); k++) begin
      adr = written_q[k];
      if (adr[11:10] == 2'd2) begin
        read_expect("bank 2 data after retention", adr, shadow[adr[11:2]]);
      end
    end
    write_reg(RET_ADR, 32'h0, 4'hf, acked);
    read_expect("retention cleared", RET_ADR, '0);

    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_chk.fail_count);
    if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hw/mini_mcu_pkg.sv
hw/bus_decoder.sv
hw/memory_bank.sv
hw/power_ctrl_regs.sv
hw/wb_resp_mux.sv
hw/mini_mcu_top.sv
tests/mini_mcu_chk.sv
tests/tb_mini_mcu.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the banked RAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -f flist.f \
    --top-module tb_mini_mcu -Mdir "$OBJ"; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_mini_mcu" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
